//--- verilog.f
verilog/host_pkg.sv
verilog/lcd_pkg.sv
verilog/spirw_slave.sv
verilog/reg_file.sv
verilog/lcd_pixel.sv
verilog/lcd_bridge_top.sv
verif/lcd_bridge_properties.sv
verif/lcd_bridge_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = lcd_bridge_tb
FILELIST = verilog.f

OBJ  = obj_dir
BIN  = $(OBJ)/V$(TOP)
LOG  = sim.log
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- verif/lcd_bridge_tb.sv
`timescale 1ns/1ps

// testbench for the host spi to st7789 bridge
// host spi master model, display monitor, register model
module lcd_bridge_tb
  import lcd_pkg::*;
;

  localparam int addr_bytes  = 1;
  // a plot has to outlast a 9-byte host frame for the back-pressure test
  localparam int lcd_clk_div = 8;
  // clk cycles per half spi bit
  localparam int half_bit    = 8;
  localparam int plot_cycles = plot_len * (16 * lcd_clk_div + 1) + 2 * lcd_clk_div + 4;
  // planned host bytes, host frames and plots over all tests
  localparam int frame_bytes = 330;
  localparam int frame_count = 58;
  localparam int plot_count  = 23;
  localparam int cycle_limit =
    4 * (frame_bytes * 16 * half_bit + frame_count * 32 + plot_count * plot_cycles);

  logic clk;
  logic reset;
  logic spi_csn;
  logic spi_clk;
  logic spi_mosi;
  logic spi_miso;
  logic lcd_clk;
  logic lcd_mosi;
  logic lcd_dc;
  logic lcd_csn;
  logic lcd_busy;

  // register model
  logic [7:0] model [0:255];
  logic [7:0] tx_buf [0:15];
  logic [7:0] rx_buf [0:15];
  // bytes seen on the display link
  lcd_byte_t  lcd_q [$];
  logic       monitor_on;
  logic [2:0] mon_bits;
  logic [7:0] mon_shift;
  int         stray_edges;
  time        last_csn_fall;
  int         errors;
  int         cycles;

  lcd_bridge_top
  #(
    .addr_bytes  (addr_bytes),
    .lcd_clk_div (lcd_clk_div)
  )
  lcd_bridge_top_inst
  (
    .clk      (clk),
    .reset    (reset),
    .spi_csn  (spi_csn),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .lcd_clk  (lcd_clk),
    .lcd_mosi (lcd_mosi),
    .lcd_dc   (lcd_dc),
    .lcd_csn  (lcd_csn),
    .lcd_busy (lcd_busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout, run went past %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  // display samples mosi on rising lcd_clk
  always @(posedge lcd_clk)
  begin
    if (monitor_on)
    begin
      if (lcd_csn)
      begin
        stray_edges = stray_edges + 1;
      end
      else
      begin
        mon_shift = {mon_shift[6:0], lcd_mosi};
        if (mon_bits == 3'd7)
        begin
          lcd_q.push_back('{dc: lcd_dc, data: mon_shift});
        end
        mon_bits = mon_bits + 3'd1;
      end
    end
  end

  always @(negedge lcd_csn)
  begin
    mon_bits      = '0;
    last_csn_fall = $time;
  end

  task check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      errors = errors + 1;
      $display("ERROR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // one spi byte in mode 0, entered and left at a falling clk edge
  task spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--)
    begin
      spi_mosi = tx[i];
      repeat (half_bit) @(negedge clk);
      rx[i]   = spi_miso;
      spi_clk = 1'b1;
      repeat (half_bit) @(negedge clk);
      spi_clk = 1'b0;
    end
  endtask

  task spi_frame(input logic rd, input logic [7:0] addr, input int n);
    logic [7:0] dummy;
    @(negedge clk);
    spi_csn = 1'b0;
    repeat (half_bit) @(negedge clk);
    spi_byte(rd ? 8'h01 : 8'h00, dummy);
    spi_byte(addr, dummy);
    for (int k = 0; k < n; k++)
    begin
      spi_byte(rd ? 8'h00 : tx_buf[k], rx_buf[k]);
    end
    repeat (half_bit) @(negedge clk);
    spi_csn = 1'b1;
    repeat (2 * half_bit) @(negedge clk);
  endtask

  task write_burst(input logic [7:0] addr, input int n);
    logic [7:0] a;
    spi_frame(1'b0, addr, n);
    for (int k = 0; k < n; k++)
    begin
      a        = addr + 8'(k);
      model[a] = tx_buf[k];
    end
  endtask

  task read_compare(input logic [7:0] addr, input int n);
    logic [7:0] a;
    spi_frame(1'b1, addr, n);
    for (int k = 0; k < n; k++)
    begin
      a = addr + 8'(k);
      check($sformatf("reg[%0d]", a), model[a], rx_buf[k]);
    end
  endtask

  // pixel registers then the plot register in one burst
  task write_plot(input logic [15:0] x, input logic [15:0] y, input logic [15:0] color);
    tx_buf[0] = x[15:8];
    tx_buf[1] = x[7:0];
    tx_buf[2] = y[15:8];
    tx_buf[3] = y[7:0];
    tx_buf[4] = color[15:8];
    tx_buf[5] = color[7:0];
    tx_buf[6] = 8'($urandom);
    write_burst(8'd0, 7);
  endtask

  task wait_busy(input logic level);
    int n;
    n = 0;
    while (lcd_busy !== level && n < 4 * plot_cycles)
    begin
      @(negedge clk);
      n = n + 1;
    end
    if (lcd_busy !== level)
    begin
      errors = errors + 1;
      $display("lcd_busy never went to %0b", level);
    end
  endtask

  // caset x x, raset y y, ramwr color
  function automatic lcd_byte_t expected_byte(input int i, input logic [15:0] x,
                                              input logic [15:0] y,
                                              input logic [15:0] color);
    case (i)
      0:       return '{dc: 1'b0, data: 8'h2A};
      1, 3:    return '{dc: 1'b1, data: x[15:8]};
      2, 4:    return '{dc: 1'b1, data: x[7:0]};
      5:       return '{dc: 1'b0, data: 8'h2B};
      6, 8:    return '{dc: 1'b1, data: y[15:8]};
      7, 9:    return '{dc: 1'b1, data: y[7:0]};
      10:      return '{dc: 1'b0, data: 8'h2C};
      11:      return '{dc: 1'b1, data: color[15:8]};
      default: return '{dc: 1'b1, data: color[7:0]};
    endcase
  endfunction

  task check_plot(input logic [15:0] x, input logic [15:0] y, input logic [15:0] color);
    lcd_byte_t got;
    lcd_byte_t exp;
    if (lcd_q.size() < plot_len)
    begin
      errors = errors + 1;
      $display("display transaction had wrong byte count, %0d bytes", lcd_q.size());
      lcd_q.delete();
    end
    else
    begin
      for (int i = 0; i < plot_len; i++)
      begin
        got = lcd_q.pop_front();
        exp = expected_byte(i, x, y, color);
        check("lcd_dc", exp.dc, got.dc);
        check("lcd_mosi", exp.data, got.data);
      end
    end
  endtask

  task run_plot;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] color;
    x     = 16'($urandom);
    y     = 16'($urandom);
    color = 16'($urandom);
    lcd_q.delete();
    write_plot(x, y, color);
    wait_busy(1'b1);
    wait_busy(1'b0);
    check("display byte count", plot_len, lcd_q.size());
    check_plot(x, y, color);
  endtask

  initial
  begin
    logic [15:0] x1;
    logic [15:0] y1;
    logic [15:0] c1;
    logic [15:0] x2;
    logic [15:0] y2;
    logic [15:0] c2;
    logic [7:0]  a;
    time         busy_fall;
    void'($urandom(32'h9d0c_4f44));
    errors      = 0;
    cycles      = 0;
    stray_edges = 0;
    monitor_on  = 1'b0;
    mon_bits    = '0;
    mon_shift   = '0;
    reset       = 1'b1;
    spi_csn     = 1'b1;
    spi_clk     = 1'b0;
    spi_mosi    = 1'b0;
    for (int i = 0; i < 256; i++)
    begin
      model[i] = 8'h00;
    end
    repeat (2) @(negedge clk);
    reset      = 1'b0;
    monitor_on = 1'b1;

    // idle state after reset
    check("lcd_busy", 1'b0, lcd_busy);
    check("lcd_csn", 1'b1, lcd_csn);
    check("lcd_clk", 1'b1, lcd_clk);
    read_compare(8'd6, 1);

    // single writes away from the plot register, then reads
    for (int i = 0; i < 16; i++)
    begin
      a         = 8'(7 + $urandom % 249);
      tx_buf[0] = 8'($urandom);
      write_burst(a, 1);
      read_compare(a, 1);
    end

    // burst wraps from 255 to 0
    for (int k = 0; k < 10; k++)
    begin
      tx_buf[k] = 8'($urandom);
    end
    write_burst(8'd250, 10);
    read_compare(8'd250, 10);
    check("display byte count", 0, lcd_q.size());

    run_plot();

    // second plot queued while the first is still on the display
    x1 = 16'($urandom);
    y1 = 16'($urandom);
    c1 = 16'($urandom);
    x2 = 16'($urandom);
    y2 = 16'($urandom);
    c2 = 16'($urandom);
    lcd_q.delete();
    write_plot(x1, y1, c1);
    wait_busy(1'b1);
    write_plot(x2, y2, c2);
    check("lcd_busy", 1'b1, lcd_busy);
    wait_busy(1'b0);
    busy_fall = $time;
    wait_busy(1'b1);
    wait_busy(1'b0);
    check("display byte count", 2 * plot_len, lcd_q.size());
    if (last_csn_fall <= busy_fall)
    begin
      errors = errors + 1;
      $display("second display transaction started before lcd_busy fell");
    end
    check_plot(x1, y1, c1);
    check_plot(x2, y2, c2);

    for (int i = 0; i < 20; i++)
    begin
      run_plot();
    end

    if (stray_edges != 0)
    begin
      errors = errors + 1;
      $display("display clocked %0d bits while lcd_csn was high", stray_edges);
    end

    $display("errors: %0d", errors);
    if (errors == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- verif/lcd_bridge_properties.sv
`timescale 1ns/1ps

// display link and plot flow properties
module lcd_bridge_properties
(
  input logic clk,
  input logic reset,
  input logic plot_req,
  input logic busy,
  input logic lcd_clk,
  input logic lcd_dc,
  input logic lcd_csn
);

  // plotter takes the request at once
  busy_after_req: assert property (@(posedge clk) disable iff (reset)
    plot_req |=> busy)
    else $error("busy did not rise the cycle after plot_req");

  // busy only rises for an accepted request
  busy_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(busy) |-> $past(plot_req))
    else $error("busy rose without plot_req");

  // dc only moves between bytes
  dc_stable: assert property (@(posedge clk) disable iff (reset)
    (lcd_clk != $past(lcd_clk)) |-> $stable(lcd_dc))
    else $error("lcd_dc changed on an lcd_clk edge");

  idle_csn_high: assert property (@(posedge clk) disable iff (reset)
    !busy |-> lcd_csn)
    else $error("lcd_csn low while not busy");

endmodule

bind lcd_pixel lcd_bridge_properties lcd_pixel_props
(
  .clk      (clk),
  .reset    (reset),
  .plot_req (plot_req),
  .busy     (busy),
  .lcd_clk  (lcd_clk),
  .lcd_dc   (lcd_dc),
  .lcd_csn  (lcd_csn)
);

// display pins are not visible in the register file
bind reg_file lcd_bridge_properties reg_file_props
(
  .clk      (clk),
  .reset    (reset),
  .plot_req (plot_req),
  .busy     (busy),
  .lcd_clk  (1'b1),
  .lcd_dc   (1'b0),
  .lcd_csn  (1'b1)
);

//--- verilog/lcd_bridge_top.sv
`timescale 1ns/1ps

// host spi to st7789 pixel bridge
// host writes x, y, color into registers 0 to 5, then writes register 6
module lcd_bridge_top
  import host_pkg::*, lcd_pkg::*;
#(
  parameter int addr_bytes  = 1,
  parameter int lcd_clk_div = 4
)
(
  input  logic clk,
  input  logic reset,
  input  logic spi_csn,
  input  logic spi_clk,
  input  logic spi_mosi,
  output logic spi_miso,
  output logic lcd_clk,
  output logic lcd_mosi,
  output logic lcd_dc,
  output logic lcd_csn,
  output logic lcd_busy
);

  // slave to register file
  reg_bus_t  bus;
  reg_byte_t rdata;
  // register file to plotter
  logic      plot_req;
  pixel_t    pixel;

  spirw_slave
  #(
    .addr_bytes(addr_bytes)
  )
  spirw_slave_inst
  (
    .clk      (clk),
    .reset    (reset),
    .spi_csn  (spi_csn),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .rdata    (rdata),
    .spi_miso (spi_miso),
    .bus      (bus)
  );

  reg_file reg_file_inst
  (
    .clk      (clk),
    .reset    (reset),
    .bus      (bus),
    .busy     (lcd_busy),
    .rdata    (rdata),
    .plot_req (plot_req),
    .pixel    (pixel)
  );

  lcd_pixel
  #(
    .lcd_clk_div(lcd_clk_div)
  )
  lcd_pixel_inst
  (
    .clk      (clk),
    .reset    (reset),
    .plot_req (plot_req),
    .pixel    (pixel),
    .busy     (lcd_busy),
    .lcd_clk  (lcd_clk),
    .lcd_mosi (lcd_mosi),
    .lcd_dc   (lcd_dc),
    .lcd_csn  (lcd_csn)
  );

endmodule

//--- verilog/lcd_pixel.sv
`timescale 1ns/1ps

// st7789 single pixel plotter
// sends caset, raset and ramwr for one pixel, 13 bytes under one csn
// lcd_clk idles high, mosi changes on falling edge
module lcd_pixel
  import lcd_pkg::*;
#(
  // clk cycles per half period of lcd_clk
  parameter int lcd_clk_div = 4
)
(
  input  logic   clk,
  input  logic   reset,
  input  logic   plot_req,
  input  pixel_t pixel,
  output logic   busy,
  output logic   lcd_clk,
  output logic   lcd_mosi,
  output logic   lcd_dc,
  output logic   lcd_csn
);

  localparam int div_w = (lcd_clk_div > 1) ? $clog2(lcd_clk_div) : 1;

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_shift,
    st_end
  } state_t;

  state_t           state;
  // pixel as accepted, later register writes do not reach it
  pixel_t           pix;
  lcd_byte_t        seq [plot_len];
  logic [3:0]       byte_idx;
  logic [2:0]       bit_cnt;
  logic [7:0]       shifter;
  logic [div_w-1:0] div_cnt;
  logic             div_done;

  assign div_done = (div_cnt == div_w'(lcd_clk_div - 1));

  // byte sequence of one plot
  // start and end of each window are the same pixel
  always_comb
  begin
    seq[0]  = '{dc: 1'b0, data: lcd_caset};
    seq[1]  = '{dc: 1'b1, data: pix.x[15:8]};
    seq[2]  = '{dc: 1'b1, data: pix.x[7:0]};
    seq[3]  = '{dc: 1'b1, data: pix.x[15:8]};
    seq[4]  = '{dc: 1'b1, data: pix.x[7:0]};
    seq[5]  = '{dc: 1'b0, data: lcd_raset};
    seq[6]  = '{dc: 1'b1, data: pix.y[15:8]};
    seq[7]  = '{dc: 1'b1, data: pix.y[7:0]};
    seq[8]  = '{dc: 1'b1, data: pix.y[15:8]};
    seq[9]  = '{dc: 1'b1, data: pix.y[7:0]};
    seq[10] = '{dc: 1'b0, data: lcd_ramwr};
    // one rgb565 pixel, high byte first
    seq[11] = '{dc: 1'b1, data: pix.color[15:8]};
    seq[12] = '{dc: 1'b1, data: pix.color[7:0]};
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= st_idle;
      busy     <= 1'b0;
      lcd_csn  <= 1'b1;
      lcd_clk  <= 1'b1;
      lcd_mosi <= 1'b0;
      lcd_dc   <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      byte_idx <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          lcd_clk <= 1'b1;
          if (plot_req)
          begin
            pix      <= pixel;
            busy     <= 1'b1;
            byte_idx <= '0;
            state    <= st_load;
          end
        end
        st_load:
        begin
          // dc set before the first falling edge of the byte
          shifter <= seq[byte_idx].data;
          lcd_dc  <= seq[byte_idx].dc;
          lcd_csn <= 1'b0;
          bit_cnt <= '0;
          div_cnt <= '0;
          state   <= st_shift;
        end
        st_shift:
        begin
          div_cnt <= div_done ? '0 : div_cnt + 1'b1;
          if (div_done)
          begin
            lcd_clk <= ~lcd_clk;
            if (lcd_clk)
            begin
              // falling edge, next bit out msb first
              lcd_mosi <= shifter[7];
              shifter  <= {shifter[6:0], 1'b0};
            end
            else
            begin
              // rising edge, display samples here
              bit_cnt <= bit_cnt + 3'd1;
              if (bit_cnt == 3'd7)
              begin
                if (byte_idx == 4'(plot_len - 1))
                begin
                  state <= st_end;
                end
                else
                begin
                  byte_idx <= byte_idx + 4'd1;
                  state    <= st_load;
                end
              end
            end
          end
        end
        st_end:
        begin
          // hold csn low for one half period after the last rising edge
          div_cnt <= div_done ? '0 : div_cnt + 1'b1;
          if (div_done)
          begin
            lcd_csn <= 1'b1;
            busy    <= 1'b0;
            state   <= st_idle;
          end
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

// 256-byte register file behind the host slave
// registers 0 to 5 are mirrored into pixel
// a write to register 6 queues one plot
module reg_file
  import host_pkg::*, lcd_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  reg_bus_t  bus,
  input  logic      busy,
  output reg_byte_t rdata,
  output logic      plot_req,
  output pixel_t    pixel
);

  reg_byte_t mem [0:256-1];
  // plot requested but not yet taken by the plotter
  logic      pending;

  // registers read back as zero after reset
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 256; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (bus.wr)
    begin
      mem[bus.addr] <= bus.wdata;
    end
  end

  // registered read, one cycle after rd
  always_ff @(posedge clk)
  begin
    if (bus.rd)
    begin
      rdata <= mem[bus.addr];
    end
  end

  // shadow of registers 0 to 5
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pixel <= '0;
    end
    else if (bus.wr)
    begin
      case (bus.addr)
        reg_x_hi:     pixel.x[15:8]     <= bus.wdata;
        reg_x_lo:     pixel.x[7:0]      <= bus.wdata;
        reg_y_hi:     pixel.y[15:8]     <= bus.wdata;
        reg_y_lo:     pixel.y[7:0]      <= bus.wdata;
        reg_color_hi: pixel.color[15:8] <= bus.wdata;
        reg_color_lo: pixel.color[7:0]  <= bus.wdata;
        default:
        begin
        end
      endcase
    end
  end

  // plotter latches pixel in the same cycle
  assign plot_req = pending & ~busy;

  // repeated plot writes while pending merge into one
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pending <= 1'b0;
    end
    else if (bus.wr && bus.addr == reg_plot)
    begin
      pending <= 1'b1;
    end
    else if (plot_req)
    begin
      pending <= 1'b0;
    end
  end

endmodule

//--- verilog/spirw_slave.sv
`timescale 1ns/1ps

// host spi slave, mode 0
// frame is command byte, address bytes, then data bytes
// pins are oversampled in clk, so spi_clk must stay below clk/8
module spirw_slave
  import host_pkg::*;
#(
  // address bytes after the command, msb first
  parameter int addr_bytes = 1
)
(
  input  logic      clk,
  input  logic      reset,
  input  logic      spi_csn,
  input  logic      spi_clk,
  input  logic      spi_mosi,
  input  reg_byte_t rdata,
  output logic      spi_miso,
  output reg_bus_t  bus
);

  typedef enum logic [1:0] {
    st_idle,
    st_cmd,
    st_addr,
    st_data
  } state_t;

  state_t     state;
  // two-flop synchronisers, bit 1 is the usable sample
  logic [1:0] csn_sync;
  logic [1:0] sclk_sync;
  logic [1:0] mosi_sync;
  // spi_clk one cycle back, for edge detect
  logic       sclk_d;
  logic       sclk_rise;
  logic       sclk_fall;
  logic [2:0] bit_cnt;
  reg_byte_t  shift_in;
  reg_byte_t  rx_byte;
  reg_byte_t  shift_out;
  // next address to write or fetch
  reg_addr_t  addr;
  logic [7:0] addr_cnt;
  logic       is_read;
  // read data arrives the cycle after rd
  logic       rd_d;

  assign sclk_rise = sclk_sync[1] & ~sclk_d;
  assign sclk_fall = ~sclk_sync[1] & sclk_d;
  // byte as it stands including the current bit
  assign rx_byte   = {shift_in[6:0], mosi_sync[1]};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      csn_sync  <= 2'b11;
      sclk_sync <= 2'b00;
      mosi_sync <= 2'b00;
      sclk_d    <= 1'b0;
    end
    else
    begin
      csn_sync  <= {csn_sync[0], spi_csn};
      sclk_sync <= {sclk_sync[0], spi_clk};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      sclk_d    <= sclk_sync[1];
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= st_idle;
      bit_cnt  <= '0;
      bus.wr   <= 1'b0;
      bus.rd   <= 1'b0;
      rd_d     <= 1'b0;
      spi_miso <= 1'b0;
    end
    else
    begin
      // strobes last one cycle
      bus.wr <= 1'b0;
      bus.rd <= 1'b0;
      rd_d   <= bus.rd;
      if (csn_sync[1])
      begin
        // deselect aborts whatever frame was running
        state    <= st_idle;
        bit_cnt  <= '0;
        spi_miso <= 1'b0;
      end
      else if (state == st_idle)
      begin
        state   <= st_cmd;
        bit_cnt <= '0;
      end
      else
      begin
        // mosi in on rising spi_clk
        if (sclk_rise)
        begin
          shift_in <= rx_byte;
          bit_cnt  <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7)
          begin
            case (state)
              st_cmd:
              begin
                is_read  <= |(rx_byte & cmd_read);
                addr_cnt <= '0;
                state    <= st_addr;
              end
              st_addr:
              begin
                // only the last, least significant byte is kept
                addr     <= rx_byte;
                addr_cnt <= addr_cnt + 8'd1;
                if (addr_cnt == 8'(addr_bytes - 1))
                begin
                  state <= st_data;
                  if (is_read)
                  begin
                    // fetch first byte ahead of the data phase
                    bus.rd   <= 1'b1;
                    bus.addr <= rx_byte;
                    addr     <= rx_byte + 8'd1;
                  end
                end
              end
              st_data:
              begin
                // auto-increment, wraps at 255
                bus.addr <= addr;
                addr     <= addr + 8'd1;
                if (is_read)
                begin
                  bus.rd <= 1'b1;
                end
                else
                begin
                  bus.wr    <= 1'b1;
                  bus.wdata <= rx_byte;
                end
              end
              default:
              begin
              end
            endcase
          end
        end
        // load fetched byte, then miso out on falling spi_clk
        if (rd_d)
        begin
          shift_out <= rdata;
        end
        else if (sclk_fall && state == st_data && is_read)
        begin
          spi_miso  <= shift_out[7];
          shift_out <= {shift_out[6:0], 1'b0};
        end
      end
    end
  end

endmodule

//--- verilog/lcd_pkg.sv
// display side of the bridge
// pixel, display byte and st7789 command codes
package lcd_pkg;

  // pixel coordinate
  typedef logic [15:0] coord_t;

  // rgb565 color
  typedef logic [15:0] color_t;

  // one plot request, 48 bits
  typedef struct packed {
    coord_t x;
    coord_t y;
    color_t color;
  } pixel_t;

  // one byte on the display link
  // dc low for command, high for data
  typedef struct packed {
    logic       dc;
    logic [7:0] data;
  } lcd_byte_t;

  // column address set
  localparam logic [7:0] lcd_caset = 8'h2A;
  // row address set
  localparam logic [7:0] lcd_raset = 8'h2B;
  // memory write
  localparam logic [7:0] lcd_ramwr = 8'h2C;

  // caset + 4, raset + 4, ramwr + 2
  localparam int plot_len = 13;

endpackage

//--- verilog/host_pkg.sv
// host side of the bridge
// register access types and register map
package host_pkg;

  // register address and data byte
  typedef logic [7:0] reg_addr_t;
  typedef logic [7:0] reg_byte_t;

  // one register access, slave to register file
  typedef struct packed {
    logic      wr;
    logic      rd;
    reg_addr_t addr;
    reg_byte_t wdata;
  } reg_bus_t;

  // pixel registers, high byte first
  localparam reg_addr_t reg_x_hi     = 8'd0;
  localparam reg_addr_t reg_x_lo     = 8'd1;
  localparam reg_addr_t reg_y_hi     = 8'd2;
  localparam reg_addr_t reg_y_lo     = 8'd3;
  localparam reg_addr_t reg_color_hi = 8'd4;
  localparam reg_addr_t reg_color_lo = 8'd5;
  // any write here requests a plot
  localparam reg_addr_t reg_plot     = 8'd6;

  // command byte mask, bit 0 set means read
  localparam reg_byte_t cmd_read = 8'h01;

endpackage
